//--- common/core_pkg.sv
`default_nettype none

package core_pkg;

	// data and address width
	localparam int xlen = 32;

	//////////////////////////////
	// instruction classes
	//////////////////////////////

	typedef enum logic [3:0] {
		op_r,
		op_i,
		op_load,
		op_store,
		op_branch,
		op_lui,
		op_auipc,
		op_jal,
		op_jalr,
		op_system,
		op_illegal
	} op_class_t;

	typedef enum logic [3:0] {
		alu_add,
		alu_sub,
		alu_and,
		alu_or,
		alu_xor,
		alu_slt,
		alu_sltu,
		alu_sll,
		alu_srl,
		alu_sra,
		alu_pass_b
	} alu_op_t;

	typedef enum logic [1:0] {
		mem_fetch,
		mem_load,
		mem_store
	} mem_kind_t;

	//////////////////////////////
	// rv32i major opcodes
	//////////////////////////////

	localparam logic [6:0] opc_r      = 7'b0110011;
	localparam logic [6:0] opc_i      = 7'b0010011;
	localparam logic [6:0] opc_load   = 7'b0000011;
	localparam logic [6:0] opc_store  = 7'b0100011;
	localparam logic [6:0] opc_branch = 7'b1100011;
	localparam logic [6:0] opc_lui    = 7'b0110111;
	localparam logic [6:0] opc_auipc  = 7'b0010111;
	localparam logic [6:0] opc_jal    = 7'b1101111;
	localparam logic [6:0] opc_jalr   = 7'b1100111;
	localparam logic [6:0] opc_system = 7'b1110011;

endpackage

`default_nettype wire

//--- common/core_ifs.sv
`timescale 1ns/1ps
`default_nettype none

// decoded fields of the current instruction
interface decode_if;
	core_pkg::op_class_t      op_class;
	logic [4:0]               rd;
	logic [4:0]               rs1;
	logic [4:0]               rs2;
	logic [2:0]               func3;
	logic [core_pkg::xlen-1:0] imm;
	core_pkg::alu_op_t        alu_op;

	modport source (output op_class, rd, rs1, rs2, func3, imm, alu_op);
	modport sink (input op_class, func3, imm, alu_op);
	modport regs (input rs1, rs2);
endinterface

// single request, single done pulse
interface mem_req_if;
	logic                      req;
	core_pkg::mem_kind_t       kind;
	logic [core_pkg::xlen-1:0] addr;
	logic [core_pkg::xlen-1:0] wdata;
	logic                      done;
	logic [core_pkg::xlen-1:0] rdata;

	modport requester (output req, kind, addr, wdata, input done, rdata);
	modport servant (input req, kind, addr, wdata, output done, rdata);
endinterface

`default_nettype wire

//--- decode/instr_decoder.sv
`timescale 1ns/1ps
`default_nettype none

module instr_decoder (
	input  logic [core_pkg::xlen-1:0] instr,
	decode_if.source                  dec
);

	logic [core_pkg::xlen-1:0] imm_i;
	logic [core_pkg::xlen-1:0] imm_s;
	logic [core_pkg::xlen-1:0] imm_b;
	logic [core_pkg::xlen-1:0] imm_u;
	logic [core_pkg::xlen-1:0] imm_j;

	assign dec.rd = instr[11:7];
	assign dec.rs1 = instr[19:15];
	assign dec.rs2 = instr[24:20];
	assign dec.func3 = instr[14:12];

	//////////////////////////////
	// immediates
	//////////////////////////////

	assign imm_i = {{20{instr[31]}}, instr[31:20]};
	assign imm_s = {{20{instr[31]}}, instr[31:25], instr[11:7]};
	assign imm_b = {{20{instr[31]}}, instr[7], instr[30:25], instr[11:8], 1'b0};
	assign imm_u = {instr[31:12], 12'b0};
	assign imm_j = {{12{instr[31]}}, instr[19:12], instr[20], instr[30:21], 1'b0};

	always_comb begin
		case (instr[6:0])
			core_pkg::opc_r:      dec.op_class = core_pkg::op_r;
			core_pkg::opc_i:      dec.op_class = core_pkg::op_i;
			core_pkg::opc_load:   dec.op_class = core_pkg::op_load;
			core_pkg::opc_store:  dec.op_class = core_pkg::op_store;
			core_pkg::opc_branch: dec.op_class = core_pkg::op_branch;
			core_pkg::opc_lui:    dec.op_class = core_pkg::op_lui;
			core_pkg::opc_auipc:  dec.op_class = core_pkg::op_auipc;
			core_pkg::opc_jal:    dec.op_class = core_pkg::op_jal;
			core_pkg::opc_jalr:   dec.op_class = core_pkg::op_jalr;
			core_pkg::opc_system: dec.op_class = core_pkg::op_system;
			default:              dec.op_class = core_pkg::op_illegal;
		endcase

		case (dec.op_class)
			core_pkg::op_store:                      dec.imm = imm_s;
			core_pkg::op_branch:                     dec.imm = imm_b;
			core_pkg::op_lui, core_pkg::op_auipc:    dec.imm = imm_u;
			core_pkg::op_jal:                        dec.imm = imm_j;
			default:                                 dec.imm = imm_i;
		endcase
	end

	// alu operation from func3, bit 30 picks sub or sra
	always_comb begin
		dec.alu_op = core_pkg::alu_add;
		if (dec.op_class == core_pkg::op_branch) begin
			dec.alu_op = core_pkg::alu_sub;
		end else if (dec.op_class inside {core_pkg::op_r, core_pkg::op_i}) begin
			case (dec.func3)
				3'b000: dec.alu_op = (dec.op_class == core_pkg::op_r && instr[30]) ?
					core_pkg::alu_sub : core_pkg::alu_add;
				3'b001: dec.alu_op = core_pkg::alu_sll;
				3'b010: dec.alu_op = core_pkg::alu_slt;
				3'b011: dec.alu_op = core_pkg::alu_sltu;
				3'b100: dec.alu_op = core_pkg::alu_xor;
				3'b101: dec.alu_op = instr[30] ? core_pkg::alu_sra : core_pkg::alu_srl;
				3'b110: dec.alu_op = core_pkg::alu_or;
				default: dec.alu_op = core_pkg::alu_and;
			endcase
		end
	end

endmodule

`default_nettype wire

//--- source/register_file.sv
`timescale 1ns/1ps
`default_nettype none

module register_file (
	input  logic                      clk,
	input  logic                      reset,
	decode_if.regs                    dec,
	output logic [core_pkg::xlen-1:0] rs1_value,
	output logic [core_pkg::xlen-1:0] rs2_value,
	input  logic                      rd_write,
	input  logic [4:0]                rd_addr,
	input  logic [core_pkg::xlen-1:0] rd_data
);

	// x0 has no storage
	logic [core_pkg::xlen-1:0] regs [1:31];

	always_ff @(posedge clk) begin
		if (reset) begin
			for (int i = 1; i < 32; i++)
				regs[i] <= '0;
		end else if (rd_write && rd_addr != 5'd0) begin
			regs[rd_addr] <= rd_data;
		end
	end

	// asynchronous reads
	assign rs1_value = (dec.rs1 == 5'd0) ? '0 : regs[dec.rs1];
	assign rs2_value = (dec.rs2 == 5'd0) ? '0 : regs[dec.rs2];

endmodule

`default_nettype wire

//--- source/alu.sv
`timescale 1ns/1ps
`default_nettype none

module alu (
	input  logic [core_pkg::xlen-1:0] a,
	input  logic [core_pkg::xlen-1:0] b,
	input  core_pkg::alu_op_t         op,
	output logic [core_pkg::xlen-1:0] result,
	output logic                      eq,
	output logic                      lt,
	output logic                      ltu
);

	logic [4:0] shamt;

	assign shamt = b[4:0];

	// compare flags, shared by branches and slt
	assign eq = (a == b);
	assign lt = ($signed(a) < $signed(b));
	assign ltu = (a < b);

	always_comb begin
		case (op)
			core_pkg::alu_add:    result = a + b;
			core_pkg::alu_sub:    result = a - b;
			core_pkg::alu_and:    result = a & b;
			core_pkg::alu_or:     result = a | b;
			core_pkg::alu_xor:    result = a ^ b;
			core_pkg::alu_slt:    result = {{(core_pkg::xlen-1){1'b0}}, lt};
			core_pkg::alu_sltu:   result = {{(core_pkg::xlen-1){1'b0}}, ltu};
			core_pkg::alu_sll:    result = a << shamt;
			core_pkg::alu_srl:    result = a >> shamt;
			core_pkg::alu_sra:    result = $signed(a) >>> shamt;
			core_pkg::alu_pass_b: result = b;
			default:              result = a + b;
		endcase
	end

endmodule

`default_nettype wire

//--- source/memory_access.sv
`timescale 1ns/1ps
`default_nettype none

module memory_access (
	input  logic                      clk,
	input  logic                      reset,
	mem_req_if.servant                mem,
	output logic                      wb_cyc,
	output logic                      wb_stb,
	output logic                      wb_we,
	output logic [core_pkg::xlen-1:0] wb_adr,
	output logic [core_pkg::xlen-1:0] wb_dat_o,
	output logic [3:0]                wb_sel,
	input  logic [core_pkg::xlen-1:0] wb_dat_i,
	input  logic                      wb_ack
);

	logic finish;

	assign finish = wb_cyc && wb_ack;

	// word accesses only
	assign wb_sel = 4'hf;
	assign wb_stb = wb_cyc;

	//////////////////////////////
	// wishbone classic cycle
	//////////////////////////////

	always_ff @(posedge clk) begin
		if (reset) begin
			wb_cyc <= 1'b0;
			wb_we <= 1'b0;
			mem.done <= 1'b0;
		end else begin
			mem.done <= finish;
			if (finish) begin
				wb_cyc <= 1'b0;
				wb_we <= 1'b0;
			end else if (mem.req) begin
				wb_cyc <= 1'b1;
				wb_we <= (mem.kind == core_pkg::mem_store);
			end
		end
	end

	// address, write data and read data held per transfer
	always_ff @(posedge clk) begin
		if (mem.req && !wb_cyc) begin
			wb_adr <= mem.addr;
			wb_dat_o <= mem.wdata;
		end
		if (finish)
			mem.rdata <= wb_dat_i;
	end

endmodule

`default_nettype wire

//--- control/core_control.sv
`timescale 1ns/1ps
`default_nettype none

module core_control #(
	parameter logic [core_pkg::xlen-1:0] reset_vector = '0
) (
	input  logic                      clk,
	input  logic                      reset,
	decode_if.sink                    dec,
	mem_req_if.requester              mem,
	output logic [core_pkg::xlen-1:0] instr,
	input  logic [core_pkg::xlen-1:0] rs1_value,
	input  logic [core_pkg::xlen-1:0] rs2_value,
	output logic                      rd_write,
	output logic [core_pkg::xlen-1:0] rd_data,
	output logic [core_pkg::xlen-1:0] alu_a,
	output logic [core_pkg::xlen-1:0] alu_b,
	output core_pkg::alu_op_t         alu_op_sel,
	input  logic [core_pkg::xlen-1:0] alu_result,
	input  logic                      branch_eq,
	input  logic                      branch_lt,
	input  logic                      branch_ltu,
	output logic                      halted
);

	typedef enum logic [2:0] {s_fetch, s_execute, s_memory, s_writeback, s_halt} state_t;

	state_t                    state;
	logic [core_pkg::xlen-1:0] pc;
	logic [core_pkg::xlen-1:0] pc_plus4;
	logic [core_pkg::xlen-1:0] branch_target;
	logic [core_pkg::xlen-1:0] next_pc;
	logic                      busy;
	logic                      taken;
	logic                      is_mem;
	logic                      is_stop;
	logic                      writes_rd;
	logic                      is_jump;

	//////////////////////////////
	// operand and target select
	//////////////////////////////

	assign is_mem = dec.op_class inside {core_pkg::op_load, core_pkg::op_store};
	assign is_stop = dec.op_class inside {core_pkg::op_system, core_pkg::op_illegal};
	assign is_jump = dec.op_class inside {core_pkg::op_jal, core_pkg::op_jalr};
	assign writes_rd = dec.op_class inside {core_pkg::op_r, core_pkg::op_i, core_pkg::op_lui,
		core_pkg::op_auipc, core_pkg::op_jal, core_pkg::op_jalr};

	assign alu_a = dec.op_class inside {core_pkg::op_auipc, core_pkg::op_jal} ? pc : rs1_value;
	assign alu_b = dec.op_class inside {core_pkg::op_r, core_pkg::op_branch} ? rs2_value : dec.imm;
	assign alu_op_sel = (dec.op_class == core_pkg::op_lui) ? core_pkg::alu_pass_b :
		(dec.op_class inside {core_pkg::op_auipc, core_pkg::op_jal}) ? core_pkg::alu_add : dec.alu_op;

	assign pc_plus4 = pc + 32'd4;
	assign branch_target = pc + dec.imm;

	always_comb begin
		case (dec.func3)
			3'b000:  taken = branch_eq;
			3'b001:  taken = !branch_eq;
			3'b100:  taken = branch_lt;
			3'b101:  taken = !branch_lt;
			3'b110:  taken = branch_ltu;
			3'b111:  taken = !branch_ltu;
			default: taken = 1'b0;
		endcase
		next_pc = pc_plus4;
		if (dec.op_class == core_pkg::op_branch && taken)
			next_pc = branch_target;
		else if (dec.op_class == core_pkg::op_jal)
			next_pc = alu_result;
		else if (dec.op_class == core_pkg::op_jalr)
			next_pc = {alu_result[core_pkg::xlen-1:1], 1'b0};
	end

	// writeback source
	assign rd_write = (state == s_writeback) || (state == s_execute && writes_rd);
	assign rd_data = (state == s_writeback) ? mem.rdata : (is_jump ? pc_plus4 : alu_result);

	// bus request, one cycle per transfer
	assign mem.req = (state == s_fetch || state == s_memory) && !busy;
	assign mem.addr = (state == s_fetch) ? pc : alu_result;
	assign mem.wdata = rs2_value;
	assign mem.kind = (state == s_fetch) ? core_pkg::mem_fetch :
		(dec.op_class == core_pkg::op_store) ? core_pkg::mem_store : core_pkg::mem_load;

	assign halted = (state == s_halt);

	//////////////////////////////
	// instruction state machine
	//////////////////////////////

	always_ff @(posedge clk) begin
		if (reset) begin
			state <= s_fetch;
			pc <= reset_vector;
			busy <= 1'b0;
		end else begin
			if (mem.done)
				busy <= 1'b0;
			else if (mem.req)
				busy <= 1'b1;
			case (state)
				s_fetch: if (mem.done) state <= s_execute;
				s_execute: begin
					if (is_stop) begin
						state <= s_halt;
					end else begin
						pc <= next_pc;
						state <= is_mem ? s_memory : s_fetch;
					end
				end
				s_memory: begin
					if (mem.done)
						state <= (dec.op_class == core_pkg::op_load) ? s_writeback : s_fetch;
				end
				s_writeback: state <= s_fetch;
				default: state <= s_halt;
			endcase
		end
	end

	// instruction register
	always_ff @(posedge clk) begin
		if (state == s_fetch && mem.done)
			instr <= mem.rdata;
	end

endmodule

`default_nettype wire

//--- source/core_top.sv
`timescale 1ns/1ps
`default_nettype none

module core_top #(
	parameter logic [core_pkg::xlen-1:0] reset_vector = '0
) (
	input  logic                      clk,
	input  logic                      reset,
	output logic                      wb_cyc,
	output logic                      wb_stb,
	output logic                      wb_we,
	output logic [core_pkg::xlen-1:0] wb_adr,
	output logic [core_pkg::xlen-1:0] wb_dat_o,
	output logic [3:0]                wb_sel,
	input  logic [core_pkg::xlen-1:0] wb_dat_i,
	input  logic                      wb_ack,
	output logic                      halted
);

	decode_if  dec_bus ();
	mem_req_if mem_bus ();

	logic [core_pkg::xlen-1:0] instr;
	logic [core_pkg::xlen-1:0] rs1_value;
	logic [core_pkg::xlen-1:0] rs2_value;
	logic                      rd_write;
	logic [core_pkg::xlen-1:0] rd_data;
	logic [core_pkg::xlen-1:0] alu_a;
	logic [core_pkg::xlen-1:0] alu_b;
	core_pkg::alu_op_t         alu_op_sel;
	logic [core_pkg::xlen-1:0] alu_result;
	logic                      branch_eq;
	logic                      branch_lt;
	logic                      branch_ltu;

	core_control #(.reset_vector(reset_vector)) u_control (
		.clk(clk), .reset(reset), .dec(dec_bus), .mem(mem_bus), .instr(instr),
		.rs1_value(rs1_value), .rs2_value(rs2_value), .rd_write(rd_write), .rd_data(rd_data),
		.alu_a(alu_a), .alu_b(alu_b), .alu_op_sel(alu_op_sel), .alu_result(alu_result),
		.branch_eq(branch_eq), .branch_lt(branch_lt), .branch_ltu(branch_ltu), .halted(halted)
	);

	instr_decoder u_decoder (.instr(instr), .dec(dec_bus));

	// write address comes straight from the held instruction
	register_file u_regs (
		.clk(clk), .reset(reset), .dec(dec_bus), .rs1_value(rs1_value), .rs2_value(rs2_value),
		.rd_write(rd_write), .rd_addr(dec_bus.rd), .rd_data(rd_data)
	);

	alu u_alu (
		.a(alu_a), .b(alu_b), .op(alu_op_sel), .result(alu_result),
		.eq(branch_eq), .lt(branch_lt), .ltu(branch_ltu)
	);

	memory_access u_mem (
		.clk(clk), .reset(reset), .mem(mem_bus), .wb_cyc(wb_cyc), .wb_stb(wb_stb), .wb_we(wb_we),
		.wb_adr(wb_adr), .wb_dat_o(wb_dat_o), .wb_sel(wb_sel), .wb_dat_i(wb_dat_i), .wb_ack(wb_ack)
	);

endmodule

`default_nettype wire

//--- bench/clock_gen.sv
`timescale 1ns/1ps
`default_nettype none

// free running testbench clock
module clock_gen #(
	parameter realtime half_period = 2.0
) (
	output logic clk
);

	initial clk = 1'b0;

	always #(half_period) clk = ~clk;

endmodule

`default_nettype wire

//--- bench/wb_memory_model.sv
`timescale 1ns/1ps
`default_nettype none

module wb_memory_model #(
	parameter logic [31:0] seed = 32'h0000_0001
) (
	input  logic        clk,
	input  logic        reset,
	input  logic        cyc,
	input  logic        stb,
	input  logic        we,
	input  logic [31:0] adr,
	input  logic [31:0] dat_w,
	input  logic [3:0]  sel,
	output logic [31:0] dat_r,
	output logic        ack
);

	localparam int words = 1024;

	logic [31:0] mem [0:words-1];
	logic [31:0] lane_mask;
	logic        busy;
	int          wait_left;
	int          store_count;
	logic [31:0] log_addr [$];
	logic [31:0] log_data [$];

	// byte lanes enabled by sel
	assign lane_mask = {{8{sel[3]}}, {8{sel[2]}}, {8{sel[1]}}, {8{sel[0]}}};

	// fill pattern over the whole word address
	initial begin
		for (int i = 0; i < words; i++)
			mem[i] = {i[15:0] ^ 16'h5a5a, ~i[15:0]};
		dat_r = '0;
		ack = 1'b0;
		busy = 1'b0;
		wait_left = 0;
		store_count = 0;
	end

	//////////////////////////////
	// slave with random waits
	//////////////////////////////

	// one process draws every wait state from the seeded stream
	initial begin
		void'($urandom(seed));
		forever begin
			@(posedge clk);
			if (reset) begin
				ack <= 1'b0;
				busy <= 1'b0;
			end else if (ack) begin
				// master drops cyc on this edge
				ack <= 1'b0;
				busy <= 1'b0;
			end else if (cyc && stb && !busy) begin
				busy <= 1'b1;
				wait_left <= int'($urandom % 4);
			end else if (busy) begin
				if (wait_left == 0) begin
					ack <= 1'b1;
					dat_r <= mem[adr[11:2]];
					if (we) begin
						mem[adr[11:2]] <= (mem[adr[11:2]] & ~lane_mask) | (dat_w & lane_mask);
						log_addr.push_back(adr);
						log_data.push_back(dat_w);
						store_count <= store_count + 1;
					end
				end else begin
					wait_left <= wait_left - 1;
				end
			end
		end
	end

endmodule

`default_nettype wire

//--- bench/core_tb.sv
`timescale 1ns/1ps
`default_nettype none

module core_tb;

	localparam logic [31:0] val_a = 32'h8000_0001;
	localparam logic [31:0] val_b = 32'h7fff_ffff;
	localparam logic [31:0] val_c = 32'h0000_0007;
	localparam logic [31:0] val_d = 32'hffff_fff0;

	logic        clk;
	logic        reset;
	logic        wb_cyc;
	logic        wb_stb;
	logic        wb_we;
	logic [31:0] wb_adr;
	logic [31:0] wb_dat_o;
	logic [3:0]  wb_sel;
	logic [31:0] wb_dat_i;
	logic        wb_ack;
	logic        halted;

	logic [31:0] prog [$];
	logic [31:0] exp_addr [64];
	logic [31:0] exp_data [64];
	int          exp_test [64];
	int          exp_count;
	int          store_off;
	int          pc;
	int          store_idx;
	int          errors [1:6];
	int          cycle_count;
	int          limit;
	logic        first_ack_seen;
	logic        prog_ready;
	logic        run_done;

	clock_gen clocks (.clk(clk));

	core_top #(.reset_vector(32'd0)) UUT (
		.clk(clk), .reset(reset), .wb_cyc(wb_cyc), .wb_stb(wb_stb), .wb_we(wb_we),
		.wb_adr(wb_adr), .wb_dat_o(wb_dat_o), .wb_sel(wb_sel), .wb_dat_i(wb_dat_i),
		.wb_ack(wb_ack), .halted(halted)
	);

	wb_memory_model #(.seed(32'h85eb_c55b)) mem_model (
		.clk(clk), .reset(reset), .cyc(wb_cyc), .stb(wb_stb), .we(wb_we), .adr(wb_adr),
		.dat_w(wb_dat_o), .sel(wb_sel), .dat_r(wb_dat_i), .ack(wb_ack)
	);

	//////////////////////////////
	// instruction encoders
	//////////////////////////////

	function automatic logic [31:0] enc_r(input logic [6:0] f7, input logic [4:0] rs2,
		input logic [4:0] rs1, input logic [2:0] f3, input logic [4:0] rd);
		return {f7, rs2, rs1, f3, rd, core_pkg::opc_r};
	endfunction

	function automatic logic [31:0] enc_i(input int imm, input logic [4:0] rs1,
		input logic [2:0] f3, input logic [4:0] rd, input logic [6:0] opc);
		return {imm[11:0], rs1, f3, rd, opc};
	endfunction

	function automatic logic [31:0] enc_s(input int imm, input logic [4:0] rs2,
		input logic [4:0] rs1);
		return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], core_pkg::opc_store};
	endfunction

	function automatic logic [31:0] enc_b(input int imm, input logic [4:0] rs2,
		input logic [4:0] rs1, input logic [2:0] f3);
		return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], core_pkg::opc_branch};
	endfunction

	function automatic logic [31:0] enc_u(input logic [19:0] imm, input logic [4:0] rd,
		input logic [6:0] opc);
		return {imm, rd, opc};
	endfunction

	function automatic logic [31:0] enc_j(input int imm, input logic [4:0] rd);
		return {imm[20], imm[10:1], imm[11], imm[19:12], rd, core_pkg::opc_jal};
	endfunction

	// rv32i branch conditions by func3
	function automatic logic branch_rule(input logic [2:0] f3, input logic [31:0] a,
		input logic [31:0] b);
		case (f3)
			3'b000:  return a == b;
			3'b001:  return a != b;
			3'b100:  return $signed(a) < $signed(b);
			3'b101:  return $signed(a) >= $signed(b);
			3'b110:  return a < b;
			default: return a >= b;
		endcase
	endfunction

	function automatic logic [31:0] shift_right_arith(input logic [31:0] x, input int sh);
		return $unsigned($signed(x) >>> sh);
	endfunction

	function automatic int test_of_store(input int idx);
		return (idx < exp_count) ? exp_test[idx] : 6;
	endfunction

	//////////////////////////////
	// program builder
	//////////////////////////////

	task automatic emit(input logic [31:0] word);
		prog.push_back(word);
		pc += 4;
	endtask

	task automatic store_result(input logic [4:0] rs, input logic [31:0] value, input int test);
		emit(enc_s(store_off, rs, 5'd10));
		exp_addr[exp_count] = 32'h400 + store_off;
		exp_data[exp_count] = value;
		exp_test[exp_count] = test;
		exp_count++;
		store_off += 4;
	endtask

	task automatic load_const(input logic [4:0] rd, input logic [31:0] value);
		logic [31:0] up;
		up = value + 32'h800;
		emit(enc_u(up[31:12], rd, core_pkg::opc_lui));
		emit(enc_i(int'(value), rd, 3'b000, rd, core_pkg::opc_i));
	endtask

	// marker in x8 tells which path ran
	task automatic branch_case(input logic [2:0] f3, input logic [4:0] rs1, input logic [4:0] rs2,
		input logic [31:0] va, input logic [31:0] vb, input int marker);
		emit(enc_b(12, rs2, rs1, f3));
		emit(enc_i(marker, 5'd0, 3'b000, 5'd8, core_pkg::opc_i));
		emit(enc_j(8, 5'd0));
		emit(enc_i(marker + 1, 5'd0, 3'b000, 5'd8, core_pkg::opc_i));
		store_result(5'd8, branch_rule(f3, va, vb) ? marker + 1 : marker, 5);
	endtask

	task automatic build_program();
		int ld_off;
		int p;
		emit(enc_i(32'h400, 5'd0, 3'b000, 5'd10, core_pkg::opc_i));
		load_const(5'd1, val_a);
		load_const(5'd2, val_b);
		load_const(5'd3, val_c);
		load_const(5'd4, val_d);

		// register class
		emit(enc_r(7'h00, 5'd2, 5'd1, 3'b000, 5'd5));
		store_result(5'd5, val_a + val_b, 3);
		emit(enc_r(7'h20, 5'd2, 5'd1, 3'b000, 5'd5));
		store_result(5'd5, val_a - val_b, 3);
		emit(enc_r(7'h00, 5'd3, 5'd1, 3'b001, 5'd5));
		store_result(5'd5, val_a << val_c[4:0], 3);
		emit(enc_r(7'h00, 5'd2, 5'd1, 3'b010, 5'd5));
		store_result(5'd5, ($signed(val_a) < $signed(val_b)) ? 32'd1 : 32'd0, 3);
		emit(enc_r(7'h00, 5'd1, 5'd2, 3'b010, 5'd5));
		store_result(5'd5, ($signed(val_b) < $signed(val_a)) ? 32'd1 : 32'd0, 3);
		emit(enc_r(7'h00, 5'd2, 5'd1, 3'b011, 5'd5));
		store_result(5'd5, (val_a < val_b) ? 32'd1 : 32'd0, 3);
		emit(enc_r(7'h00, 5'd2, 5'd1, 3'b100, 5'd5));
		store_result(5'd5, val_a ^ val_b, 3);
		emit(enc_r(7'h00, 5'd3, 5'd4, 3'b101, 5'd5));
		store_result(5'd5, val_d >> val_c[4:0], 3);
		emit(enc_r(7'h20, 5'd3, 5'd4, 3'b101, 5'd5));
		store_result(5'd5, shift_right_arith(val_d, 7), 3);
		emit(enc_r(7'h00, 5'd4, 5'd1, 3'b110, 5'd5));
		store_result(5'd5, val_a | val_d, 3);
		emit(enc_r(7'h00, 5'd4, 5'd1, 3'b111, 5'd5));
		store_result(5'd5, val_a & val_d, 3);

		// immediate class, sign extended
		emit(enc_i(-5, 5'd1, 3'b000, 5'd5, core_pkg::opc_i));
		store_result(5'd5, val_a + 32'hffff_fffb, 3);
		emit(enc_i(-1, 5'd4, 3'b010, 5'd5, core_pkg::opc_i));
		store_result(5'd5, ($signed(val_d) < -1) ? 32'd1 : 32'd0, 3);
		emit(enc_i(-1, 5'd4, 3'b011, 5'd5, core_pkg::opc_i));
		store_result(5'd5, (val_d < 32'hffff_ffff) ? 32'd1 : 32'd0, 3);
		emit(enc_i(32'h555, 5'd1, 3'b100, 5'd5, core_pkg::opc_i));
		store_result(5'd5, val_a ^ 32'h0000_0555, 3);
		emit(enc_i(32'h0f0, 5'd4, 3'b110, 5'd5, core_pkg::opc_i));
		store_result(5'd5, val_d | 32'h0000_00f0, 3);
		emit(enc_i(-256, 5'd1, 3'b111, 5'd5, core_pkg::opc_i));
		store_result(5'd5, val_a & 32'hffff_ff00, 3);
		emit(enc_i(4, 5'd1, 3'b001, 5'd5, core_pkg::opc_i));
		store_result(5'd5, val_a << 4, 3);
		emit(enc_i(8, 5'd4, 3'b101, 5'd5, core_pkg::opc_i));
		store_result(5'd5, val_d >> 8, 3);
		emit(enc_i(32'h408, 5'd4, 3'b101, 5'd5, core_pkg::opc_i));
		store_result(5'd5, shift_right_arith(val_d, 8), 3);

		// upper immediates, load round trip, x0
		emit(enc_u(20'habcde, 5'd6, core_pkg::opc_lui));
		store_result(5'd6, 32'habcd_e000, 4);
		p = pc;
		emit(enc_u(20'h12345, 5'd6, core_pkg::opc_auipc));
		store_result(5'd6, p + 32'h1234_5000, 4);
		ld_off = store_off;
		store_result(5'd1, val_a, 4);
		emit(enc_i(ld_off, 5'd10, 3'b010, 5'd7, core_pkg::opc_load));
		store_result(5'd7, val_a, 4);
		emit(enc_i(99, 5'd0, 3'b000, 5'd0, core_pkg::opc_i));
		store_result(5'd0, 32'd0, 4);

		// every condition taken and not taken
		branch_case(3'b000, 5'd1, 5'd1, val_a, val_a, 16);
		branch_case(3'b000, 5'd1, 5'd2, val_a, val_b, 18);
		branch_case(3'b001, 5'd1, 5'd2, val_a, val_b, 20);
		branch_case(3'b001, 5'd1, 5'd1, val_a, val_a, 22);
		branch_case(3'b100, 5'd1, 5'd2, val_a, val_b, 24);
		branch_case(3'b100, 5'd2, 5'd1, val_b, val_a, 26);
		branch_case(3'b101, 5'd2, 5'd1, val_b, val_a, 28);
		branch_case(3'b101, 5'd1, 5'd2, val_a, val_b, 30);
		branch_case(3'b110, 5'd1, 5'd2, val_a, val_b, 32);
		branch_case(3'b110, 5'd2, 5'd1, val_b, val_a, 34);
		branch_case(3'b111, 5'd1, 5'd2, val_a, val_b, 36);
		branch_case(3'b111, 5'd2, 5'd1, val_b, val_a, 38);

		// jumps skip a stray store
		p = pc;
		emit(enc_j(8, 5'd9));
		emit(enc_s(32'h7f0, 5'd9, 5'd10));
		store_result(5'd9, p + 4, 5);
		p = pc;
		emit(enc_u(20'h0, 5'd11, core_pkg::opc_auipc));
		emit(enc_i(13, 5'd11, 3'b000, 5'd9, core_pkg::opc_jalr));
		emit(enc_s(32'h7f0, 5'd9, 5'd10));
		store_result(5'd9, p + 8, 5);

		emit(32'h0010_0073);
	endtask

	task automatic report_error(input int test, input string msg);
		$display("Error at %0t ns: test %0d, %s", $time, test, msg);
		errors[test]++;
	endtask

	//////////////////////////////
	// assertions
	//////////////////////////////

	always @(posedge clk) begin
		if (!reset && wb_cyc && wb_ack) begin
			first_ack_seen <= 1'b1;
			if (wb_we)
				store_idx <= store_idx + 1;
		end
	end

	a_reset: assert property (@(posedge clk)
		reset |=> (!wb_cyc && !wb_stb && !wb_we && !halted))
		else report_error(1, "bus or halted active in reset");

	a_first_fetch: assert property (@(posedge clk) disable iff (reset)
		(wb_cyc && !first_ack_seen) |-> (wb_adr == 32'd0 && !wb_we))
		else report_error(1, "first transfer is not a read at address 0");

	a_stb: assert property (@(posedge clk) disable iff (reset) wb_cyc |-> wb_stb)
		else report_error(2, "cyc without stb");

	a_sel: assert property (@(posedge clk) disable iff (reset) wb_cyc |-> (wb_sel == 4'hf))
		else report_error(2, "byte select not all ones");

	a_hold: assert property (@(posedge clk) disable iff (reset)
		(wb_cyc && !wb_ack) |=> (wb_cyc && wb_stb && $stable(wb_adr) && $stable(wb_we)
		&& $stable(wb_dat_o)))
		else report_error(2, "transfer changed before ack");

	a_store: assert property (@(posedge clk) disable iff (reset)
		(wb_cyc && wb_we && wb_ack) |-> (store_idx < exp_count
		&& wb_adr == exp_addr[store_idx] && wb_dat_o == exp_data[store_idx]))
		else report_error(test_of_store(store_idx), "store address or data mismatch");

	// a jalr target keeps bit 0 clear
	a_read_align: assert property (@(posedge clk) disable iff (reset)
		(wb_cyc && !wb_we) |-> (wb_adr[1:0] == 2'b00))
		else report_error(5, "read address not word aligned after jump");

	a_halt_hold: assert property (@(posedge clk) disable iff (reset)
		halted |=> (halted && !wb_cyc))
		else report_error(6, "bus activity or halted drop after ebreak");

	a_store_count: assert property (@(posedge clk) disable iff (reset)
		$rose(halted) |-> (mem_model.store_count == exp_count))
		else report_error(6, "store count differs from table size");

	//////////////////////////////
	// stimulus and reporting
	//////////////////////////////

	initial begin
		string names [1:6];
		int total;
		int passed;
		names[1] = "reset and first fetch";
		names[2] = "wishbone rules";
		names[3] = "register and immediate arithmetic";
		names[4] = "upper immediates, loads and stores";
		names[5] = "branches and jumps";
		names[6] = "halt";
		reset = 1'b1;
		first_ack_seen = 1'b0;
		prog_ready = 1'b0;
		run_done = 1'b0;
		store_idx = 0;
		exp_count = 0;
		store_off = 0;
		pc = 0;
		cycle_count = 0;
		for (int t = 1; t <= 6; t++)
			errors[t] = 0;

		@(posedge clk);
		build_program();
		for (int i = 0; i < prog.size(); i++)
			mem_model.mem[i] = prog[i];
		limit = prog.size() * 12 + 40;
		prog_ready = 1'b1;
		repeat (2) @(posedge clk);
		reset <= 1'b0;

		while (!first_ack_seen)
			@(posedge clk);
		$display("test 1 %s: %0d errors", names[1], errors[1]);

		wait (halted);
		repeat (20) @(posedge clk);

		// slave log against the expected-store table
		for (int i = 0; i < mem_model.log_addr.size(); i++) begin
			a_log: assert (i < exp_count && mem_model.log_addr[i] == exp_addr[i]
				&& mem_model.log_data[i] == exp_data[i])
				else report_error(test_of_store(i), "logged store differs from table");
		end

		run_done = 1'b1;
		total = 0;
		passed = 0;
		for (int t = 2; t <= 6; t++)
			$display("test %0d %s: %0d errors", t, names[t], errors[t]);
		for (int t = 1; t <= 6; t++) begin
			total += errors[t];
			if (errors[t] == 0)
				passed++;
		end
		$display("tests passed %0d of 6, failed %0d, errors %0d", passed, 6 - passed, total);
		if (total == 0)
			$display("ALL CHECKS PASSED");
		else
			$display("CHECKS FAILED");
		$finish;
	end

	// stall guard, scaled by program length
	initial begin
		wait (prog_ready);
		while (!run_done && cycle_count < limit) begin
			@(posedge clk);
			cycle_count++;
		end
		if (!run_done) begin
			$display("timeout: core did not halt within %0d cycles", limit);
			$display("CHECKS FAILED");
			$finish;
		end
	end

endmodule

`default_nettype wire

//--- build.f
common/core_pkg.sv
common/core_ifs.sv
decode/instr_decoder.sv
source/register_file.sv
source/alu.sv
source/memory_access.sv
control/core_control.sv
source/core_top.sv
bench/clock_gen.sv
bench/wb_memory_model.sv
bench/core_tb.sv

//--- run_sim.sh
#!/bin/sh
# build and run the core testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 --top-module core_tb -f build.f \
	-o core_tb_sim > build.log 2>&1 \
	|| { echo "Verilator build failed, see build.log"; exit 1; }

./obj_dir/core_tb_sim > sim.log 2>&1
cat sim.log
grep -q "CHECKS FAILED" sim.log && { echo "simulation reported failures"; exit 1; } \
	|| { grep -q "ALL CHECKS PASSED" sim.log && exit 0 || exit 1; }
